//--- design/aes_defines.svh
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

////////////////////////////////////////////////////////////
// Sizes shared by the RTL and the testbench
////////////////////////////////////////////////////////////

// Bytes in one AES state block
`define AES_BLOCK_BYTES 16

// Wishbone byte address width
// Covers 16 key bytes plus data and status registers
`define WB_ADDR_W 5

// Result bytes held before the host reads them
// Power of two so the FIFO pointers wrap on their own
`define RESULT_FIFO_DEPTH 16

`endif

//--- design/busPkg.sv
`default_nettype none

`include "aes_defines.svh"

package busPkg;

    ////////////////////////////////////////////////////////////
    // Wishbone classic, 8-bit data
    ////////////////////////////////////////////////////////////

    // Master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`WB_ADDR_W-1:0] adr;
        logic [7:0]            dat;
    } wbReqT;

    // Slave to master
    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wbRspT;

    // Register map
    // KEY0..KEY15 write only, one round-key byte each
    // STATUS bit 0 result available, bit 1 input ready
    typedef enum logic [`WB_ADDR_W-1:0] {
        KEY[16]  = 5'h00,
        DATA_IN  = 5'h10,
        DATA_OUT = 5'h11,
        STATUS   = 5'h12
    } regAddrE;

endpackage

`default_nettype wire

//--- design/aesPkg.sv
`default_nettype none

`include "aes_defines.svh"

package aesPkg;

    ////////////////////////////////////////////////////////////
    // Stream and key types
    ////////////////////////////////////////////////////////////

    // One byte on a valid/ready link, ready runs separately
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byteStreamT;

    // Byte i applies to state index i = row + 4 * column
    typedef logic [`AES_BLOCK_BYTES-1:0][7:0] keyBlockT;

    // Per-bank state in the row shifter
    typedef enum logic [1:0] {
        EMPTY,
        FULL,
        DRAINING
    } bankStateE;

    ////////////////////////////////////////////////////////////
    // Inverse S-box
    ////////////////////////////////////////////////////////////

    // FIPS-197 table, one row per high nibble
    // Entry 0 sits in the leftmost byte
    localparam logic [0:255][7:0] INV_SBOX = {
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    // Plain table lookup
    function automatic logic [7:0] invSbox(input logic [7:0] b);
        return INV_SBOX[b];
    endfunction

endpackage

`default_nettype wire

//--- design/wbSlaveRegs.sv
`timescale 1ns/10ps
`default_nettype none

`include "aes_defines.svh"

module wbSlaveRegs (
    input  logic               clock,
    input  logic               arstN,
    input  busPkg::wbReqT      wbReq,
    output busPkg::wbRspT      wbRsp,
    output aesPkg::byteStreamT inStream,
    input  logic               inReady,
    output aesPkg::keyBlockT   roundKey,
    input  logic [7:0]         resultByte,
    input  logic [4:0]         resultCount,
    output logic               resultPop
);

    typedef enum logic [1:0] {IDLE, WAIT_PUSH, WAIT_POP, ACK} busStateE;

    busStateE        state;
    busPkg::regAddrE addr;
    logic            request;
    logic            isKey;
    logic            isPush;
    logic            isPop;
    logic            pushDone;
    logic            haveResult;
    logic [7:0]      statusByte;
    logic [7:0]      readData;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////
    assign request = wbReq.cyc && wbReq.stb;
    assign addr    = busPkg::regAddrE'(wbReq.adr);
    // Upper address half holds the data and status registers
    assign isKey   = !wbReq.adr[`WB_ADDR_W-1];
    assign isPush  = request && wbReq.we && (addr == busPkg::DATA_IN);
    assign isPop   = request && !wbReq.we && (addr == busPkg::DATA_OUT);

    // Push straight from the held bus data
    assign inStream.valid = isPush && (state == IDLE || state == WAIT_PUSH);
    assign inStream.data  = wbReq.dat;
    assign pushDone       = inStream.valid && inReady;

    // Pop only when the FIFO has something
    assign haveResult = (resultCount != 5'd0);
    assign resultPop  = isPop && (state == IDLE || state == WAIT_POP) && haveResult;

    assign statusByte = {6'b000000, inReady, haveResult};

    ////////////////////////////////////////////////////////////
    // Bus FSM and key store
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state    <= IDLE;
            roundKey <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (isPush) begin
                        state <= pushDone ? ACK : WAIT_PUSH;
                    end else if (isPop) begin
                        state <= resultPop ? ACK : WAIT_POP;
                    end else if (request) begin
                        state <= ACK;
                        if (wbReq.we && isKey) begin
                            roundKey[wbReq.adr[3:0]] <= wbReq.dat;
                        end
                    end
                end
                // Stalled by the row shifter
                WAIT_PUSH: if (pushDone) state <= ACK;
                // Stalled on an empty FIFO
                WAIT_POP:  if (resultPop) state <= ACK;
                // One-cycle ack, then back for the next request
                default:   state <= IDLE;
            endcase
        end
    end

    // Read data, popped byte wins over status
    always_ff @(posedge clock) begin
        if (resultPop) begin
            readData <= resultByte;
        end else if (state == IDLE && request && !wbReq.we) begin
            readData <= (addr == busPkg::STATUS) ? statusByte : 8'h00;
        end
    end

    assign wbRsp.ack = (state == ACK);
    assign wbRsp.dat = readData;

endmodule

`default_nettype wire

//--- design/invShiftRows.sv
`timescale 1ns/10ps
`default_nettype none

`include "aes_defines.svh"

module invShiftRows (
    input  logic               clock,
    input  logic               arstN,
    input  aesPkg::byteStreamT inStream,
    output logic               inReady,
    output aesPkg::byteStreamT outStream,
    input  logic               outReady
);

    // Two banks, one fills while the other drains
    logic [7:0]        bankMem [2][`AES_BLOCK_BYTES];
    aesPkg::bankStateE bankState [2];
    logic [$clog2(`AES_BLOCK_BYTES)-1:0] wrIdx [2];
    logic [$clog2(`AES_BLOCK_BYTES)-1:0] rdIdx [2];

    logic       fillSel;
    logic       drainSel;
    logic       inFire;
    logic       outFire;
    logic [1:0] outRow;
    logic [1:0] outCol;
    logic [1:0] srcCol;
    logic [$clog2(`AES_BLOCK_BYTES)-1:0] srcIdx;

    ////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////

    // Fill bank still busy means both banks hold data
    assign inReady = (bankState[fillSel] == aesPkg::EMPTY);
    assign inFire  = inStream.valid && inReady;

    assign outStream.valid = (bankState[drainSel] != aesPkg::EMPTY);
    assign outFire         = outStream.valid && outReady;

    // Output byte (r, c) comes from input byte (r, c - r)
    assign outRow = rdIdx[drainSel][1:0];
    assign outCol = rdIdx[drainSel][3:2];
    assign srcCol = outCol - outRow;
    assign srcIdx = {srcCol, outRow};

    assign outStream.data = bankMem[drainSel][srcIdx];

    ////////////////////////////////////////////////////////////
    // Bank control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            fillSel  <= 1'b0;
            drainSel <= 1'b0;
            for (int b = 0; b < 2; b++) begin
                bankState[b] <= aesPkg::EMPTY;
                wrIdx[b]     <= '0;
                rdIdx[b]     <= '0;
            end
        end else begin
            // Sixteenth byte closes the bank and flips the fill side
            if (inFire) begin
                wrIdx[fillSel] <= wrIdx[fillSel] + 1'b1;
                if (wrIdx[fillSel] == 4'(`AES_BLOCK_BYTES - 1)) begin
                    bankState[fillSel] <= aesPkg::FULL;
                    fillSel            <= !fillSel;
                end
            end
            // Last byte out frees the bank for the fill side
            if (outFire) begin
                rdIdx[drainSel] <= rdIdx[drainSel] + 1'b1;
                if (rdIdx[drainSel] == 4'(`AES_BLOCK_BYTES - 1)) begin
                    bankState[drainSel] <= aesPkg::EMPTY;
                    drainSel            <= !drainSel;
                end else begin
                    bankState[drainSel] <= aesPkg::DRAINING;
                end
            end
        end
    end

    // Bank storage, written in arrival order
    always_ff @(posedge clock) begin
        if (inFire) begin
            bankMem[fillSel][wrIdx[fillSel]] <= inStream.data;
        end
    end

endmodule

`default_nettype wire

//--- design/invSubKeyAdd.sv
`timescale 1ns/10ps
`default_nettype none

`include "aes_defines.svh"

module invSubKeyAdd (
    input  logic               clock,
    input  logic               arstN,
    input  aesPkg::byteStreamT inStream,
    output logic               inReady,
    input  aesPkg::keyBlockT   roundKey,
    input  logic               resultPop,
    output logic [7:0]         resultByte,
    output logic [4:0]         resultCount
);

    logic [7:0] fifoMem [`RESULT_FIFO_DEPTH];
    logic [$clog2(`RESULT_FIFO_DEPTH)-1:0] wrPtr;
    logic [$clog2(`RESULT_FIFO_DEPTH)-1:0] rdPtr;
    logic [4:0] count;

    // Position within the block, selects the key byte
    logic [$clog2(`AES_BLOCK_BYTES)-1:0] bytePos;

    logic       stageValid;
    logic [7:0] stageByte;
    logic       inFire;
    logic       popFire;

    ////////////////////////////////////////////////////////////
    // Flow control
    ////////////////////////////////////////////////////////////

    // Room needed for the staged byte and the new one
    assign inReady = (count + {4'b0000, stageValid}) < 5'(`RESULT_FIFO_DEPTH);
    assign inFire  = inStream.valid && inReady;
    // Ignore pops on an empty FIFO
    assign popFire = resultPop && (count != 5'd0);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            stageValid <= 1'b0;
            bytePos    <= '0;
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
        end else begin
            stageValid <= inFire;
            if (inFire) bytePos <= bytePos + 1'b1;
            // Staged byte always lands in the FIFO next cycle
            if (stageValid) wrPtr <= wrPtr + 1'b1;
            if (popFire) rdPtr <= rdPtr + 1'b1;
            count <= count + {4'b0000, stageValid} - {4'b0000, popFire};
        end
    end

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////

    // InvSubBytes then AddRoundKey
    always_ff @(posedge clock) begin
        if (inFire) begin
            stageByte <= aesPkg::invSbox(inStream.data) ^ roundKey[bytePos];
        end
        if (stageValid) begin
            fifoMem[wrPtr] <= stageByte;
        end
    end

    // Show-ahead head of the FIFO
    assign resultByte  = fifoMem[rdPtr];
    assign resultCount = count;

endmodule

`default_nettype wire

//--- design/aesInvFinalRound.sv
`timescale 1ns/10ps
`default_nettype none

module aesInvFinalRound (
    input  logic          clock,
    input  logic          arstN,
    input  busPkg::wbReqT wbReq,
    output busPkg::wbRspT wbRsp
);

    // Bus side to row shifter
    aesPkg::byteStreamT shiftIn;
    logic               shiftInReady;
    // Row shifter to substitution and key add
    aesPkg::byteStreamT shiftOut;
    logic               subInReady;
    // Key and result path back to the bus
    aesPkg::keyBlockT   roundKey;
    logic [7:0]         resultByte;
    logic [4:0]         resultCount;
    logic               resultPop;

    wbSlaveRegs wbSlaveRegs_i (
        .clock       (clock),
        .arstN       (arstN),
        .wbReq       (wbReq),
        .wbRsp       (wbRsp),
        .inStream    (shiftIn),
        .inReady     (shiftInReady),
        .roundKey    (roundKey),
        .resultByte  (resultByte),
        .resultCount (resultCount),
        .resultPop   (resultPop)
    );

    invShiftRows invShiftRows_i (
        .clock     (clock),
        .arstN     (arstN),
        .inStream  (shiftIn),
        .inReady   (shiftInReady),
        .outStream (shiftOut),
        .outReady  (subInReady)
    );

    invSubKeyAdd invSubKeyAdd_i (
        .clock       (clock),
        .arstN       (arstN),
        .inStream    (shiftOut),
        .inReady     (subInReady),
        .roundKey    (roundKey),
        .resultPop   (resultPop),
        .resultByte  (resultByte),
        .resultCount (resultCount)
    );

endmodule

`default_nettype wire

//--- bench/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen (
    output logic clock,
    output logic arstN
);

    // 40 ns period
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 16;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Release just after an edge so the DUT sees a clean reset exit
    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2 arstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/aesInvFinalRound_properties.sv
`timescale 1ns/10ps
`default_nettype none

module aesInvFinalRound_properties (
    input logic               clock,
    input logic               arstN,
    input busPkg::wbReqT      wbReq,
    input busPkg::wbRspT      wbRsp,
    input aesPkg::byteStreamT shiftOut,
    input logic               subInReady
);

    ////////////////////////////////////////////////////////////
    // Wishbone side
    ////////////////////////////////////////////////////////////

    // Ack is a single pulse
    ackSinglePulse: assert property (@(posedge clock) disable iff (!arstN)
        wbRsp.ack |=> !wbRsp.ack)
        else $error("ack stayed high for two cycles");

    // Ack only answers a live request
    ackNeedsRequest: assert property (@(posedge clock) disable iff (!arstN)
        $rose(wbRsp.ack) |-> (wbReq.cyc && wbReq.stb))
        else $error("ack rose without cyc and stb");

    ////////////////////////////////////////////////////////////
    // Internal byte stream
    ////////////////////////////////////////////////////////////

    // Row shifter output held while the key add stage stalls
    shiftOutHeld: assert property (@(posedge clock) disable iff (!arstN)
        (shiftOut.valid && !subInReady) |=> (shiftOut.valid && $stable(shiftOut.data)))
        else $error("row shifter output changed while stalled");

endmodule

bind aesInvFinalRound aesInvFinalRound_properties properties_i (
    .clock      (clock),
    .arstN      (arstN),
    .wbReq      (wbReq),
    .wbRsp      (wbRsp),
    .shiftOut   (shiftOut),
    .subInReady (subInReady)
);

`default_nettype wire

//--- bench/aesInvFinalRound_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "aes_defines.svh"

module aesInvFinalRound_tb;

    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 16;
    // 1 + 8 + 4 + 1 blocks and three key loads
    localparam int TOTAL_BLOCKS = 14;
    localparam int KEY_WRITES   = 48;
    // Generous bus turn plus gaps and polls per byte
    localparam int CYCLE_LIMIT  = RESET_CYCLES + KEY_WRITES * 8
                                  + TOTAL_BLOCKS * `AES_BLOCK_BYTES * 24;

    logic             clock;
    logic             arstN;
    busPkg::wbReqT    wbReq;
    busPkg::wbRspT    wbRsp;

    integer           seed;
    logic             busLock;
    logic             stallSeen;
    int               stallBytes;
    int               pushedBytes;
    int               checkedCount = 0;
    int               cycleCount = 0;
    aesPkg::keyBlockT modelKey;
    logic [7:0]       readQ [$];
    logic [7:0]       expQ [$];

    clockGen clockGen_i (
        .clock (clock),
        .arstN (arstN)
    );

    aesInvFinalRound aesInvFinalRound_i (
        .clock (clock),
        .arstN (arstN),
        .wbReq (wbReq),
        .wbRsp (wbRsp)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // GF(2^8) product under the AES polynomial
    function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) p ^= x;
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // Brute force inverse with zero mapped to zero
    function automatic logic [7:0] gfInverse(input logic [7:0] a);
        logic [7:0] inv;
        inv = 8'h00;
        for (int x = 1; x < 256; x++) begin
            if (gfMul(a, x[7:0]) == 8'h01) inv = x[7:0];
        end
        return inv;
    endfunction

    // Undo the affine map then invert
    function automatic logic [7:0] invSubByte(input logic [7:0] b);
        logic [7:0] y;
        y = {b[6:0], b[7]} ^ {b[4:0], b[7:5]} ^ {b[1:0], b[7:2]} ^ 8'h05;
        return gfInverse(y);
    endfunction

    // InvShiftRows, InvSubBytes and AddRoundKey on one block
    function automatic aesPkg::keyBlockT refRound(input aesPkg::keyBlockT blk,
                                                  input aesPkg::keyBlockT key);
        aesPkg::keyBlockT res;
        int               src;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                src = r + 4 * ((c - r + 4) % 4);
                res[r + 4 * c] = invSubByte(blk[src]) ^ key[r + 4 * c];
            end
        end
        return res;
    endfunction

    // Leftmost hex byte is state index 0
    function automatic aesPkg::keyBlockT fromHex(input logic [127:0] h);
        aesPkg::keyBlockT b;
        for (int i = 0; i < `AES_BLOCK_BYTES; i++) begin
            b[i] = h[127 - 8 * i -: 8];
        end
        return b;
    endfunction

    function automatic int randomBelow(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    function automatic aesPkg::keyBlockT randomBlock();
        aesPkg::keyBlockT b;
        for (int i = 0; i < `AES_BLOCK_BYTES; i++) begin
            b[i] = 8'($random(seed));
        end
        return b;
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////////////////////////

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    // One classic cycle shared by the push and read processes
    task automatic busCycle(input logic we, input logic [`WB_ADDR_W-1:0] adr,
                            input logic [7:0] wdat, output logic [7:0] rdat);
        @(posedge clock);
        while (busLock) @(posedge clock);
        busLock = 1'b1;
        #DRIVE_DELAY;
        wbReq.cyc = 1'b1;
        wbReq.stb = 1'b1;
        wbReq.we  = we;
        wbReq.adr = adr;
        wbReq.dat = wdat;
        // Ack sampled mid-cycle away from the edge
        @(negedge clock);
        while (!wbRsp.ack) @(negedge clock);
        rdat = wbRsp.dat;
        @(posedge clock);
        #DRIVE_DELAY;
        wbReq   = '0;
        busLock = 1'b0;
        // At least one idle cycle hands the bus to the other process
        repeat (1 + randomBelow(3)) @(posedge clock);
    endtask

    task automatic readStatus(output logic [7:0] status);
        busCycle(1'b0, busPkg::STATUS, 8'h00, status);
    endtask

    task automatic writeKey(input aesPkg::keyBlockT key);
        logic [7:0] unused;
        for (int i = 0; i < `AES_BLOCK_BYTES; i++) begin
            busCycle(1'b1, i[`WB_ADDR_W-1:0], key[i], unused);
        end
        modelKey = key;
    endtask

    // Waits for input ready, then pushes a whole block
    task automatic pushBlock(input aesPkg::keyBlockT blk);
        logic [7:0]       status;
        logic [7:0]       unused;
        aesPkg::keyBlockT expected;
        readStatus(status);
        while (!status[1]) begin
            if (!stallSeen) begin
                stallSeen  = 1'b1;
                stallBytes = pushedBytes;
            end
            readStatus(status);
        end
        expected = refRound(blk, modelKey);
        for (int i = 0; i < `AES_BLOCK_BYTES; i++) begin
            expQ.push_back(expected[i]);
        end
        // Fill bank stays open until its last byte
        for (int i = 0; i < `AES_BLOCK_BYTES; i++) begin
            busCycle(1'b1, busPkg::DATA_IN, blk[i], unused);
            pushedBytes++;
        end
    endtask

    // Pop only when STATUS shows a byte
    task automatic readResults(input int count);
        logic [7:0] status;
        logic [7:0] data;
        for (int i = 0; i < count; i++) begin
            readStatus(status);
            while (!status[0]) readStatus(status);
            busCycle(1'b0, busPkg::DATA_OUT, 8'h00, data);
            readQ.push_back(data);
        end
    endtask

    task automatic waitForChecks(input int target);
        while (checkedCount < target) @(posedge clock);
    endtask

    ////////////////////////////////////////////////////////////
    // Compare and timeout
    ////////////////////////////////////////////////////////////

    initial begin : compareResults
        logic [7:0] got;
        logic [7:0] want;
        forever begin
            @(posedge clock);
            while (readQ.size() > 0) begin
                got = readQ.pop_front();
                assert (expQ.size() > 0)
                    else abortRun("a result byte was read with no expected byte left");
                want = expQ.pop_front();
                assert (got === want)
                    else abortRun($sformatf("mismatch at %0t: result %0d read %02h, expected %02h",
                                            $time, checkedCount, got, want));
                checkedCount++;
            end
        end
    end

    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            abortRun($sformatf("timeout, the tests did not finish within %0d cycles",
                               CYCLE_LIMIT));
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin : runTests
        logic [7:0]       status;
        aesPkg::keyBlockT blk;
        int               checkTarget;
        seed        = 82705;
        wbReq       = '0;
        busLock     = 1'b0;
        stallSeen   = 1'b0;
        stallBytes  = 0;
        pushedBytes = 0;
        modelKey    = '0;
        checkTarget = 0;
        wait (arstN === 1'b1);
        @(posedge clock);

        // Nothing held and input open
        readStatus(status);
        assert (status[1:0] == 2'b10)
            else abortRun($sformatf("mismatch at %0t: STATUS after reset is %02h",
                                    $time, status));

        // Known answer from the last inverse round of the FIPS-197 example
        blk = fromHex(128'h6353e08c0960e104cd70b751bacad0e7);
        writeKey(fromHex(128'h000102030405060708090a0b0c0d0e0f));
        assert (refRound(blk, modelKey) == fromHex(128'h00112233445566778899aabbccddeeff))
            else abortRun($sformatf("mismatch at %0t: reference model fails the known answer",
                                    $time));
        pushBlock(blk);
        readResults(`AES_BLOCK_BYTES);
        checkTarget += `AES_BLOCK_BYTES;
        waitForChecks(checkTarget);

        // Eight blocks with a late reader running alongside
        writeKey(randomBlock());
        fork
            begin
                for (int b = 0; b < 8; b++) begin
                    pushBlock(randomBlock());
                end
            end
            begin
                repeat (randomBelow(64)) @(posedge clock);
                readResults(8 * `AES_BLOCK_BYTES);
            end
        join
        checkTarget += 8 * `AES_BLOCK_BYTES;
        waitForChecks(checkTarget);

        // Four blocks against two banks plus the FIFO
        stallSeen   = 1'b0;
        pushedBytes = 0;
        fork
            begin
                for (int b = 0; b < 4; b++) begin
                    pushBlock(randomBlock());
                end
            end
            begin
                wait (stallSeen);
                readResults(4 * `AES_BLOCK_BYTES);
            end
        join
        assert (stallBytes == 2 * `AES_BLOCK_BYTES + `RESULT_FIFO_DEPTH)
            else abortRun($sformatf("mismatch at %0t: input stalled after %0d bytes",
                                    $time, stallBytes));
        checkTarget += 4 * `AES_BLOCK_BYTES;
        waitForChecks(checkTarget);

        // New key while idle
        writeKey(randomBlock());
        pushBlock(randomBlock());
        readResults(`AES_BLOCK_BYTES);
        checkTarget += `AES_BLOCK_BYTES;
        waitForChecks(checkTarget);

        // No stray or missing result bytes
        readStatus(status);
        assert (status[1:0] == 2'b10)
            else abortRun($sformatf("mismatch at %0t: STATUS at the end is %02h",
                                    $time, status));
        assert (expQ.size() == 0 && readQ.size() == 0)
            else abortRun("expected results were left unchecked at the end");

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/busPkg.sv
design/aesPkg.sv
design/wbSlaveRegs.sv
design/invShiftRows.sv
design/invSubKeyAdd.sv
design/aesInvFinalRound.sv
bench/clockGen.sv
bench/aesInvFinalRound_properties.sv
bench/aesInvFinalRound_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= aesInvFinalRound_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(wildcard design/*.sv design/*.svh bench/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# The log decides the result, not the simulator exit code
run: compile
	-./$(BINARY) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) && echo "Simulation passed" \
		|| (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
